/* hw/fetch_types_pkg.sv */
`default_nettype none

// ==================================================
// types and address map shared by the fetch path
// ==================================================
package fetch_types_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // read bus data word

  // boot address, overridable through RESET_PC at the top
  localparam addr_t RESET_PC_DEFAULT = 32'h8000_0000;

  // sdram window, both bounds inclusive
  localparam addr_t SLOW_BASE  = 32'hA000_0000;
  localparam addr_t SLOW_LIMIT = 32'hC000_0000;

endpackage : fetch_types_pkg

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

// ==================================================
// rv32i encodings seen by the predecoder
// ==================================================
package rv_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;

  localparam opcode_t OPC_JAL      = 7'b110_1111;
  localparam opcode_t OPC_MISC_MEM = 7'b000_1111;  // fence, fence.i

  // fence.i with rd = rs1 = 0 and imm = 0
  localparam inst_t INST_FENCE_I = 32'h0000_100F;

endpackage : rv_isa_pkg

`default_nettype wire

/* hw/fetch_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// pc generator to cache
interface fetch_req_if import fetch_types_pkg::*; ();
  logic  req_valid;
  addr_t req_pc;
  logic  req_ready;  // transfer seen on the response side
  logic  flush;      // fence.i from predecode

  modport source (output req_valid, output req_pc, input req_ready);
  modport cache  (input req_valid, input req_pc, input flush, output req_ready);
endinterface : fetch_req_if

// cache to output buffer, plus redirect back to the pc
interface fetch_rsp_if import fetch_types_pkg::*, rv_isa_pkg::*; ();
  logic  rsp_valid;
  inst_t rsp_inst;
  addr_t rsp_pc;
  logic  rsp_ready;
  logic  redirect;
  addr_t redirect_pc;

  modport source  (output rsp_valid, output rsp_inst, output rsp_pc, input rsp_ready);
  modport sink    (input rsp_valid, input rsp_inst, input rsp_pc, output rsp_ready);
  modport monitor (input rsp_valid, input rsp_inst, input rsp_pc, input rsp_ready);
  modport redir   (input redirect, input redirect_pc);
endinterface : fetch_rsp_if

`default_nettype wire

/* hw/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen
  import fetch_types_pkg::*;
#(
  parameter addr_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  fetch_req_if.source req,
  fetch_rsp_if.redir  rsp_ctl
);

  addr_t pc_q;
  logic  valid_q;
  addr_t pc_next;

  // jal target wins over the sequential step
  always_comb
  begin
    if (rsp_ctl.redirect)
    begin
      pc_next = rsp_ctl.redirect_pc;
    end
    else
    begin
      pc_next = pc_q + addr_t'(4);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1;  // always fetching once out of reset
      if (req.req_ready)
      begin
        pc_q <= pc_next;
      end
    end
  end

  assign req.req_valid = valid_q;
  assign req.req_pc    = pc_q;

endmodule : pc_gen

`default_nettype wire

/* hw/icache_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_fetch
  import fetch_types_pkg::*;
#(
  parameter int unsigned IDX_W = 3
) (
  input  logic         clk,
  input  logic         rst,
  fetch_req_if.cache   req,
  fetch_rsp_if.source  rsp,
  output logic         mem_arvalid_o,
  output addr_t        mem_araddr_o,
  input  logic         mem_rvalid_i,
  input  word_t        mem_rdata_i
);

  localparam int unsigned LINES = 1 << IDX_W;
  localparam int unsigned TAG_W = 32 - IDX_W - 3;  // 2 words per line

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ0,
    GAP,
    REQ1
  } cache_state_e;

  // ==================================================
  // arrays and lookup
  // ==================================================
  word_t            data_q [LINES][2];
  tag_t             tag_q  [LINES];
  logic [LINES-1:0] valid_q;

  cache_state_e state_q;
  logic         pending_q;  // a read is outstanding

  tag_t req_tag;
  idx_t req_idx;
  logic req_off;
  logic hit;
  logic slow;

  assign req_tag = req.req_pc[31:IDX_W+3];
  assign req_idx = req.req_pc[IDX_W+2:3];
  assign req_off = req.req_pc[2];

  assign hit = req.req_valid && (state_q == IDLE) && valid_q[req_idx] &&
               (tag_q[req_idx] == req_tag);

  assign slow = (req.req_pc >= SLOW_BASE) && (req.req_pc <= SLOW_LIMIT);

  // hit path is purely combinational
  assign rsp.rsp_valid = hit;
  assign rsp.rsp_inst  = data_q[req_idx][req_off];
  assign rsp.rsp_pc    = req.req_pc;
  assign req.req_ready = rsp.rsp_valid && rsp.rsp_ready;

  // ==================================================
  // refill bus requests
  // ==================================================
  assign mem_arvalid_o = ((state_q == REQ0) || (state_q == REQ1)) && !pending_q;
  assign mem_araddr_o  = {req_tag, req_idx, (state_q == REQ1), 2'b00};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      pending_q <= 1'b0;
      valid_q   <= '0;
    end
    else
    begin
      if (mem_arvalid_o)
      begin
        pending_q <= 1'b1;
      end
      else if (mem_rvalid_i)
      begin
        pending_q <= 1'b0;
      end

      case (state_q)
        IDLE:
        begin
          // no new miss while the buffer is stalled
          if (req.req_valid && !hit && rsp.rsp_ready)
          begin
            state_q <= REQ0;
          end
        end
        REQ0:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= slow ? GAP : REQ1;
          end
        end
        GAP:
        begin
          state_q <= REQ1;  // idle cycle for the sdram window
        end
        REQ1:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= IDLE;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase

      if (req.flush)
      begin
        valid_q <= '0;  // fence.i drops every line
      end
      else if ((state_q == REQ1) && mem_rvalid_i)
      begin
        valid_q[req_idx] <= 1'b1;
      end
    end
  end

  // pc is held during refill so the lookup fields still name the line
  always_ff @(posedge clk)
  begin
    if ((state_q == REQ0) && mem_rvalid_i)
    begin
      data_q[req_idx][0] <= mem_rdata_i;
    end
    if ((state_q == REQ1) && mem_rvalid_i)
    begin
      data_q[req_idx][1] <= mem_rdata_i;
      tag_q[req_idx]     <= req_tag;
    end
  end

  // one read at a time, next strobe only after the answer
  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o |=> (!mem_arvalid_o until_with mem_rvalid_i));

  a_rvalid_in_refill: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_i |-> pending_q && (state_q inside {REQ0, REQ1}));

endmodule : icache_fetch

`default_nettype wire

/* hw/predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module predecode
  import fetch_types_pkg::*, rv_isa_pkg::*;
(
  fetch_rsp_if.monitor rsp_snoop,
  output logic         redirect_o,
  output addr_t        redirect_pc_o,
  output logic         flush_o
);

  inst_t       inst;
  opcode_t     opcode;
  logic        fire;
  logic        is_jal;
  logic        is_fence_i;
  logic [20:0] jal_imm;
  addr_t       jal_off;

  assign inst   = rsp_snoop.rsp_inst;
  assign opcode = inst[6:0];
  assign fire   = rsp_snoop.rsp_valid && rsp_snoop.rsp_ready;

  // ==================================================
  // classify
  // ==================================================
  assign is_jal = (opcode == OPC_JAL);

  // only the exact fence.i word, plain fence is ignored
  assign is_fence_i = (opcode == OPC_MISC_MEM) && (inst == INST_FENCE_I);

  // j-type immediate, bit 0 always zero
  assign jal_imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign jal_off = {{11{jal_imm[20]}}, jal_imm};

  // ==================================================
  // strobes, only on an accepted word
  // ==================================================
  assign redirect_o    = fire && is_jal;
  assign redirect_pc_o = rsp_snoop.rsp_pc + jal_off;
  assign flush_o       = fire && is_fence_i;

endmodule : predecode

`default_nettype wire

/* hw/fetch_out_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_out_buf
  import fetch_types_pkg::*, rv_isa_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  fetch_rsp_if.sink  rsp,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output inst_t      out_inst_o,
  output addr_t      out_pc_o
);

  logic  valid_q;
  inst_t inst_q;
  addr_t pc_q;
  logic  load;

  // take a new word when empty or when the current one leaves
  assign rsp.rsp_ready = !valid_q || out_ready_i;
  assign load          = rsp.rsp_valid && rsp.rsp_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (load)
    begin
      valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      valid_q <= 1'b0;  // drained
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      inst_q <= rsp.rsp_inst;
      pc_q   <= rsp.rsp_pc;
    end
  end

  assign out_valid_o = valid_q;
  assign out_inst_o  = inst_q;
  assign out_pc_o    = pc_q;

  // decode stage sees a held word until it takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_inst_o) && $stable(out_pc_o));

endmodule : fetch_out_buf

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_types_pkg::*, rv_isa_pkg::*;
#(
  parameter addr_t       RESET_PC = RESET_PC_DEFAULT,
  parameter int unsigned IDX_W    = 3
) (
  input  logic  clk,
  input  logic  rst,

  // read bus
  output logic  mem_arvalid_o,
  output addr_t mem_araddr_o,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i,

  // toward decode
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output inst_t out_inst_o,
  output addr_t out_pc_o
);

  fetch_req_if req_bus ();
  fetch_rsp_if rsp_bus ();

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) i_pc_gen (
    .clk     (clk),
    .rst     (rst),
    .req     (req_bus),
    .rsp_ctl (rsp_bus)
  );

  icache_fetch #(
    .IDX_W (IDX_W)
  ) i_icache_fetch (
    .clk           (clk),
    .rst           (rst),
    .req           (req_bus),
    .rsp           (rsp_bus),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  // strobes land on the two interfaces
  predecode i_predecode (
    .rsp_snoop     (rsp_bus),
    .redirect_o    (rsp_bus.redirect),
    .redirect_pc_o (rsp_bus.redirect_pc),
    .flush_o       (req_bus.flush)
  );

  fetch_out_buf i_fetch_out_buf (
    .clk         (clk),
    .rst         (rst),
    .rsp         (rsp_bus),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_inst_o  (out_inst_o),
    .out_pc_o    (out_pc_o)
  );

endmodule : fetch_top

`default_nettype wire

/* testbench/tb_fetch_mem.sv */
`timescale 1ns/1ps
`default_nettype none

// read bus memory, one outstanding read, answer after 1 to 4 cycles
module tb_fetch_mem
  import fetch_types_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  mem_arvalid_i,
  input  addr_t mem_araddr_i,
  output logic  mem_rvalid_o,
  output word_t mem_rdata_o,
  output addr_t look_addr_o,  // image lookup, answered by the testbench top
  input  word_t look_data_i
);

  integer      seed;
  logic        busy;
  int unsigned wait_cnt;

  initial
  begin
    seed         = 8482;
    busy         = 1'b0;
    wait_cnt     = 0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    look_addr_o  = '0;
  end

  always @(negedge clk)
  begin
    mem_rvalid_o <= 1'b0;  // one-cycle answer strobe
    if (rst)
    begin
      busy <= 1'b0;
    end
    else if (busy)
    begin
      if (wait_cnt == 1)
      begin
        mem_rvalid_o <= 1'b1;
        mem_rdata_o  <= look_data_i;
        busy         <= 1'b0;
      end
      else
      begin
        wait_cnt <= wait_cnt - 1;
      end
    end
    else if (mem_arvalid_i)
    begin
      look_addr_o <= mem_araddr_i;
      busy        <= 1'b1;
      wait_cnt    <= 1 + ($unsigned($random(seed)) % 4);
    end
  end

endmodule : tb_fetch_mem

`default_nettype wire

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top
  import fetch_types_pkg::*, rv_isa_pkg::*;
();

  // ==================================================
  // program layout
  // ==================================================
  localparam addr_t       LOOP_A         = 32'h8000_0000;
  localparam addr_t       LOOP_B         = 32'hA000_0000;
  localparam addr_t       HOP_FIRST      = 32'h8008_0000;  // jal chain toward the slow region
  localparam addr_t       HOP_STEP       = 32'h0008_0000;
  localparam int unsigned TARGET         = 1200;
  localparam int unsigned LINK_ITER      = 3;  // loop a leaves after this fence.i
  localparam int unsigned TIMEOUT_CYCLES = TARGET * 20;

  logic  clk;
  logic  rst;
  logic  mem_arvalid;
  addr_t mem_araddr;
  logic  mem_rvalid;
  word_t mem_rdata;
  logic  out_valid;
  logic  out_ready;
  inst_t out_inst;
  addr_t out_pc;
  addr_t look_addr;
  word_t look_data;

  integer      seed;
  logic        link_open;
  logic        done;
  int unsigned err_data, err_order, err_stable, err_cache, err_bus;
  int unsigned n_inst, fences_a, fences_b, rst_cycles;
  logic [7:0]  mdl_valid;  // own copy of the cache valid bits and tags
  logic [25:0] mdl_tag [8];
  int unsigned rd_phase;
  logic [28:0] rd_line;
  logic        rd_pending;
  longint      cycle, rv_cycle;
  logic        held;
  inst_t       hold_inst;
  addr_t       hold_pc;
  addr_t       exp_pc;
  word_t       img;

  function automatic word_t jal_word(addr_t pc, addr_t target);
    addr_t off;
    off = target - pc;
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
  endfunction

  // next pc in program order through the placed jumps
  function automatic addr_t next_pc(addr_t a);
    if (a == LOOP_A + 32'h1C)
      return link_open ? HOP_FIRST : LOOP_A;
    else if (a == LOOP_B + 32'h1C)
      return LOOP_B;
    else if (a >= HOP_FIRST && a < LOOP_B && a[18:0] == 19'd0)
      return a + HOP_STEP;
    else
      return a + 32'd4;
  endfunction

  function automatic word_t image_word(addr_t a);
    addr_t nxt;
    nxt = next_pc(a);
    if (a == LOOP_A + 32'h10 || a == LOOP_B + 32'h10)
      return INST_FENCE_I;
    else if (nxt != a + 32'd4)
      return jal_word(a, nxt);
    else
      return {a[31:7], 7'b001_0011};  // addi
  endfunction

  always_comb
  begin
    look_data = image_word(look_addr);
  end

  fetch_top i_fetch_top (
    .clk           (clk),
    .rst           (rst),
    .mem_arvalid_o (mem_arvalid),
    .mem_araddr_o  (mem_araddr),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .out_inst_o    (out_inst),
    .out_pc_o      (out_pc)
  );

  tb_fetch_mem i_mem (
    .clk           (clk),
    .rst           (rst),
    .mem_arvalid_i (mem_arvalid),
    .mem_araddr_i  (mem_araddr),
    .mem_rvalid_o  (mem_rvalid),
    .mem_rdata_o   (mem_rdata),
    .look_addr_o   (look_addr),
    .look_data_i   (look_data)
  );

  always #4 clk = ~clk;

  // decode stage stalls in about 30% of cycles
  always @(negedge clk)
  begin
    if (!rst)
    begin
      out_ready <= ($unsigned($random(seed)) % 100) >= 30;
    end
  end

  // ==================================================
  // checks
  // ==================================================
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (rst)
    begin
      rst_cycles = rst_cycles + 1;
      if (rst_cycles > 1)
      begin
        a_quiet: assert (!mem_arvalid && !out_valid) else
        begin
          err_bus++;
          $display("read strobe or output valid during reset at cycle %0d", cycle);
        end
      end
    end
    else
    begin
      if (mem_rvalid)
      begin
        rd_pending = 1'b0;
        rv_cycle   = cycle;
        if (rd_phase == 2)
        begin
          mdl_valid[rd_line[2:0]] = 1'b1;
          mdl_tag[rd_line[2:0]]   = rd_line[28:3];
          rd_phase                = 0;
        end
      end

      if (mem_arvalid)
      begin
        a_single: assert (!rd_pending) else
        begin
          err_bus++;
          $display("read strobe while a read is outstanding, addr %h", mem_araddr);
        end
        a_aligned: assert (mem_araddr[1:0] == 2'b00) else
        begin
          err_bus++;
          $display("misaligned read address %h", mem_araddr);
        end
        if (!mem_araddr[2])
        begin
          a_pair_start: assert (rd_phase == 0) else
          begin
            err_bus++;
            $display("even word read before the previous line finished, %h", mem_araddr);
          end
          a_no_reuse: assert (!(mdl_valid[mem_araddr[5:3]] &&
                                mdl_tag[mem_araddr[5:3]] == mem_araddr[31:6])) else
          begin
            err_cache++;
            $display("refill of a line the cache already holds, %h", mem_araddr);
          end
          rd_line  = mem_araddr[31:3];
          rd_phase = 1;
        end
        else
        begin
          a_pair_end: assert (rd_phase == 1 && rd_line == mem_araddr[31:3]) else
          begin
            err_bus++;
            $display("odd word read out of order, %h", mem_araddr);
          end
          if (mem_araddr >= SLOW_BASE && mem_araddr <= SLOW_LIMIT)
          begin
            a_gap: assert (cycle != rv_cycle + 1) else
            begin
              err_bus++;
              $display("slow region read without the idle cycle, %h", mem_araddr);
            end
          end
          rd_phase = 2;
        end
        rd_pending = 1'b1;
      end

      if (held)
      begin
        a_stable: assert (out_valid && out_inst == hold_inst && out_pc == hold_pc) else
        begin
          err_stable++;
          $display("outputs changed while the decode stage stalled, pc %h", out_pc);
        end
      end

      // a new word in the output buffer
      if (out_valid && !held)
      begin
        a_cached: assert (mdl_valid[out_pc[5:3]] && mdl_tag[out_pc[5:3]] == out_pc[31:6]) else
        begin
          err_cache++;
          $display("pc %h delivered from a line that was never read", out_pc);
        end
        if (image_word(out_pc) == INST_FENCE_I)
        begin
          mdl_valid = '0;
          if (out_pc < LOOP_B)
          begin
            fences_a = fences_a + 1;
            if (fences_a == LINK_ITER)
              link_open = 1'b1;
          end
          else
          begin
            fences_b = fences_b + 1;
          end
        end
      end

      if (out_valid && out_ready)
      begin
        img = image_word(out_pc);
        a_data: assert (out_inst == img) else
        begin
          err_data++;
          $display("MISMATCH data pc %h expected %h actual %h", out_pc, img, out_inst);
        end
        a_order: assert (out_pc == exp_pc) else
        begin
          err_order++;
          $display("MISMATCH order expected %h actual %h", exp_pc, out_pc);
        end
        exp_pc = next_pc(out_pc);
        n_inst = n_inst + 1;
        if (n_inst >= TARGET && fences_a > 0 && fences_b > 0)
          done = 1'b1;
      end

      held      = out_valid && !out_ready;
      hold_inst = out_inst;
      hold_pc   = out_pc;
    end
  end

  task automatic print_summary();
    $display("errors: data %0d order %0d stable %0d cache %0d bus %0d, instructions %0d",
             err_data, err_order, err_stable, err_cache, err_bus, n_inst);
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    out_ready  = 1'b0;
    seed       = 8482;
    link_open  = 1'b0;
    done       = 1'b0;
    err_data   = 0;
    err_order  = 0;
    err_stable = 0;
    err_cache  = 0;
    err_bus    = 0;
    n_inst     = 0;
    fences_a   = 0;
    fences_b   = 0;
    rst_cycles = 0;
    mdl_valid  = '0;
    for (int i = 0; i < 8; i++)
      mdl_tag[i] = '0;
    rd_phase   = 0;
    rd_line    = '0;
    rd_pending = 1'b0;
    cycle      = 0;
    rv_cycle   = 0;
    held       = 1'b0;
    hold_inst  = '0;
    hold_pc    = '0;
    exp_pc     = LOOP_A;
    img        = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    while (!done)
      @(posedge clk);
    print_summary();
    if (err_data + err_order + err_stable + err_cache + err_bus == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES + 16) @(posedge clk);
    $display("timeout after %0d instructions, fence.i seen %0d and %0d times",
             n_inst, fences_a, fences_b);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_fetch_top

`default_nettype wire

/* compile.f */
hw/fetch_types_pkg.sv
hw/rv_isa_pkg.sv
hw/fetch_ifs.sv
hw/pc_gen.sv
hw/icache_fetch.sv
hw/predecode.sv
hw/fetch_out_buf.sv
hw/fetch_top.sv
testbench/tb_fetch_mem.sv
testbench/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_top \
  --Mdir obj_dir -o tb_sim \
  -f compile.f

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
